// ==== design/ahb_ssram_pkg.sv ====
`include "ahb_ssram_settings.svh"

package ahb_ssram_pkg;

   // AHB transfer type as seen on HTRANS
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_e;

   // AHB transfer size as seen on HSIZE
   // Codes above WORD are legal on the bus and handled as WORD
   typedef enum logic [2:0] {
      BYTE = 3'b000,
      HALF = 3'b001,
      WORD = 3'b010
   } hsize_e;

   // Address phase controls bundled by the top level
   typedef struct packed {
      logic                sel;
      logic [`AHB_AW-1:0]  addr;
      htrans_e             trans;
      hsize_e              size;
      logic                write;
   } ahb_req_t;

   // One cycle of the single SRAM port
   // Word address only as byte select comes from wb
   typedef struct packed {
      logic                en;
      logic                we;
      logic [3:0]          wb;
      logic [`AHB_AW-3:0]  addr;
      logic [`AHB_DW-1:0]  din;
   } sram_cmd_t;

endpackage

// ==== design/ahb_ssram_settings.svh ====
`ifndef AHB_SSRAM_SETTINGS_SVH
`define AHB_SSRAM_SETTINGS_SVH

// AHB byte address width
// Low two bits pick the byte inside a word
// 12 bits gives a 4 KB window
`define AHB_AW 12

// Bus data width
// Fixed at 32 since the lane logic assumes four byte lanes
`define AHB_DW 32

// Number of 32-bit words in the bank
// One word per word address of the AHB window
`define SSRAM_DEPTH (1 << (`AHB_AW - 2))

`endif

// ==== design/ahb_ssram_top.sv ====
`timescale 1ns/1ps
`include "ahb_ssram_settings.svh"

module ahb_ssram_top
   import ahb_ssram_pkg::*;
(
   input  logic               HCLK,
   input  logic               HRESETn,
   input  logic               HSEL,
   input  logic [`AHB_AW-1:0] HADDR,
   input  htrans_e            HTRANS,
   input  hsize_e             HSIZE,
   input  logic               HWRITE,
   input  logic [`AHB_DW-1:0] HWDATA,
   output logic [`AHB_DW-1:0] HRDATA,
   output logic               HREADYOUT,
   output logic               HRESP
);

   // Address phase bundle
   ahb_req_t             ahb_req;

   // Bridge to bank
   sram_cmd_t            sram_cmd;
   logic [`AHB_DW-1:0]   sram_dout;

   // Pack the address phase controls
   assign ahb_req = '{
      sel:   HSEL,
      addr:  HADDR,
      trans: HTRANS,
      size:  HSIZE,
      write: HWRITE
   };

   // Single slave so HREADYOUT is the bus HREADY
   ahb_to_ssram ahb_to_ssram_inst (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .ahb_req   (ahb_req),
      .HREADY    (HREADYOUT),
      .HWDATA    (HWDATA),
      .HREADYOUT (HREADYOUT),
      .HRDATA    (HRDATA),
      .HRESP     (HRESP),
      .sram_cmd  (sram_cmd),
      .sram_dout (sram_dout)
   );

   // Behavioural memory behind the bridge
   ssram_bank ssram_bank_inst (
      .HCLK      (HCLK),
      .sram_cmd  (sram_cmd),
      .sram_dout (sram_dout)
   );

endmodule

// ==== design/ahb_to_ssram.sv ====
`timescale 1ns/1ps
`include "ahb_ssram_settings.svh"

module ahb_to_ssram
   import ahb_ssram_pkg::*;
(
   input  logic               HCLK,
   input  logic               HRESETn,
   input  ahb_req_t           ahb_req,
   input  logic               HREADY,
   input  logic [`AHB_DW-1:0] HWDATA,
   output logic               HREADYOUT,
   output logic [`AHB_DW-1:0] HRDATA,
   output logic               HRESP,
   output sram_cmd_t          sram_cmd,
   input  logic [`AHB_DW-1:0] sram_dout
);

   // Word address width of the SRAM port
   localparam int WAW = `AHB_AW - 2;

   // Transfer decode
   logic           trans_nonseq;
   logic           trans_seq;
   logic           trans_active;
   logic           read_valid;
   logic           write_valid;
   logic [3:0]     lanes;
   logic [WAW-1:0] live_addr;

   // Write waiting for its data phase
   logic           wr_pend;
   logic [WAW-1:0] wr_addr;
   logic [3:0]     wr_lanes;

   // Read held back by a write on the port
   logic           rd_collide;
   logic           rd_pend;
   logic [WAW-1:0] rd_addr;

   // HTRANS decode
   always_comb begin
      trans_nonseq = 1'b0;
      trans_seq    = 1'b0;
      case (ahb_req.trans)
         NONSEQ: begin
            trans_nonseq = 1'b1;
         end
         SEQ: begin
            trans_seq = 1'b1;
         end
         default: begin
            // IDLE and BUSY carry no transfer
            trans_nonseq = 1'b0;
         end
      endcase
   end

   // Bursts are plain SEQ beats here
   assign trans_active = trans_nonseq | trans_seq;

   // Only accepted when selected and the bus is ready
   assign read_valid  = trans_active & ahb_req.sel & HREADY & ~ahb_req.write;
   assign write_valid = trans_active & ahb_req.sel & HREADY & ahb_req.write;

   // Drop the byte offset
   assign live_addr = ahb_req.addr[`AHB_AW-1:2];

   // Byte lanes from size and low address bits
   always_comb begin
      case (ahb_req.size)
         BYTE: begin
            lanes = 4'b0001 << ahb_req.addr[1:0];
         end
         HALF: begin
            lanes = ahb_req.addr[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            // WORD and anything larger
            lanes = 4'b1111;
         end
      endcase
   end

   // Read address phase during a write data phase
   // Port is taken by the write so the read waits one cycle
   assign rd_collide = read_valid & wr_pend;

   // Control state
   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         wr_pend <= 1'b0;
         rd_pend <= 1'b0;
      end else begin
         // Write runs in the cycle after acceptance
         wr_pend <= write_valid;
         // Pending read lasts exactly one cycle
         rd_pend <= rd_collide;
      end
   end

   // Address and lanes of the write in flight
   always_ff @(posedge HCLK) begin
      if (write_valid) begin
         wr_addr  <= live_addr;
         wr_lanes <= lanes;
      end
   end

   // Address of the held read
   always_ff @(posedge HCLK) begin
      if (rd_collide) begin
         rd_addr <= live_addr;
      end
   end

   // SRAM port mux
   // Pending write first, then pending read, then live address phase
   always_comb begin
      sram_cmd.din = HWDATA;
      if (wr_pend) begin
         sram_cmd.en   = 1'b1;
         sram_cmd.we   = 1'b1;
         sram_cmd.wb   = wr_lanes;
         sram_cmd.addr = wr_addr;
      end else if (rd_pend) begin
         sram_cmd.en   = 1'b1;
         sram_cmd.we   = 1'b0;
         sram_cmd.wb   = 4'b0000;
         sram_cmd.addr = rd_addr;
      end else begin
         // Reads go out in their own address phase
         sram_cmd.en   = read_valid;
         sram_cmd.we   = 1'b0;
         sram_cmd.wb   = 4'b0000;
         sram_cmd.addr = live_addr;
      end
   end

   // Wait state while the held read is on the port
   assign HREADYOUT = ~rd_pend;

   // Bank output is already aligned to the data phase
   assign HRDATA = sram_dout;

   // Always OKAY
   assign HRESP = 1'b0;

endmodule

// ==== design/ssram_bank.sv ====
`timescale 1ns/1ps
`include "ahb_ssram_settings.svh"

module ssram_bank
   import ahb_ssram_pkg::*;
(
   input  logic               HCLK,
   input  sram_cmd_t          sram_cmd,
   output logic [`AHB_DW-1:0] sram_dout
);

   // Word address width and lane count
   localparam int WAW   = `AHB_AW - 2;
   localparam int LANES = `AHB_DW / 8;

   // Shared read strobe for all lanes
   logic rd_en;

   // Read when enabled without write
   assign rd_en = sram_cmd.en & ~sram_cmd.we;

   // One byte wide array per lane
   // Each lane has its own write enable like a macro with byte masks
   for (genvar i = 0; i < LANES; i++) begin : g_lane

      // Lane storage
      // No reset so contents start unknown
      logic [7:0] mem [`SSRAM_DEPTH];

      // Registered read byte
      logic [7:0] rd_q;

      // Lane write enable
      logic       wr_en;

      assign wr_en = sram_cmd.en & sram_cmd.we & sram_cmd.wb[i];

      // Write only the flagged lane
      always_ff @(posedge HCLK) begin
         if (wr_en) begin
            mem[sram_cmd.addr[WAW-1:0]] <= sram_cmd.din[8*i +: 8];
         end
      end

      // One cycle read latency
      // Output holds its value during writes and idle cycles
      always_ff @(posedge HCLK) begin
         if (rd_en) begin
            rd_q <= mem[sram_cmd.addr[WAW-1:0]];
         end
      end

      // Lane back into the word
      assign sram_dout[8*i +: 8] = rd_q;

   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AHB SRAM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f sim.f \
   --top-module ahb_ssram_tb \
   -o ahb_ssram_sim

result=$(./obj_dir/ahb_ssram_sim)
echo "$result"

# Pass only when the testbench printed its pass line
if echo "$result" | grep -qF -- '** PASS **'; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// ==== sim.f ====
+incdir+design
design/ahb_ssram_pkg.sv
design/ahb_to_ssram.sv
design/ssram_bank.sv
design/ahb_ssram_top.sv
testbench/ahb_ssram_assert.sv
testbench/ahb_ssram_tb.sv

// ==== testbench/ahb_ssram_assert.sv ====
`timescale 1ns/1ps

module ahb_ssram_assert
   import ahb_ssram_pkg::*;
(
   input logic      HCLK,
   input logic      HRESETn,
   input logic      HREADYOUT,
   input logic      HRESP,
   input sram_cmd_t sram_cmd
);

   // Only one wait state ever, for the read behind a write
   a_single_wait: assert property (@(posedge HCLK) disable iff (!HRESETn)
      !HREADYOUT |=> HREADYOUT)
      else $error("HREADYOUT low for two consecutive cycles");

   // No error responses
   a_resp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
      HRESP == 1'b0)
      else $error("HRESP not OKAY");

   // Write needs the port enabled
   a_we_en: assert property (@(posedge HCLK) disable iff (!HRESETn)
      sram_cmd.we |-> sram_cmd.en)
      else $error("SRAM write enable without port enable");

   // Strobes only during a write
   a_wb_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
      !sram_cmd.we |-> (sram_cmd.wb == 4'b0000))
      else $error("SRAM byte strobes set without write enable");

endmodule

bind ahb_to_ssram ahb_ssram_assert ahb_ssram_assert_inst (
   .HCLK      (HCLK),
   .HRESETn   (HRESETn),
   .HREADYOUT (HREADYOUT),
   .HRESP     (HRESP),
   .sram_cmd  (sram_cmd)
);

// ==== testbench/ahb_ssram_tb.sv ====
`timescale 1ns/1ps
`include "ahb_ssram_settings.svh"

module ahb_ssram_tb
   import ahb_ssram_pkg::*;
();

   localparam int CLK_PERIOD = 20;
   // Transfers over all tests at four cycles each plus a margin
   localparam int NUM_XFERS       = 16 + 18 + 8 + 12 + 68;
   localparam int WATCHDOG_CYCLES = NUM_XFERS * 4 + 100;

   // One bus transfer as the master sees it
   typedef struct packed {
      logic               sel;
      logic               write;
      htrans_e            trans;
      hsize_e             size;
      logic [`AHB_AW-1:0] addr;
      logic [`AHB_DW-1:0] data;
   } xfer_t;

   logic               HCLK;
   logic               HRESETn;
   logic               HSEL;
   logic [`AHB_AW-1:0] HADDR;
   htrans_e            HTRANS;
   hsize_e             HSIZE;
   logic               HWRITE;
   logic [`AHB_DW-1:0] HWDATA;
   logic [`AHB_DW-1:0] HRDATA;
   logic               HREADYOUT;
   logic               HRESP;

   // Byte-wide reference memory over the whole AHB window
   logic [7:0] ref_mem [1 << `AHB_AW];
   xfer_t      xq [$];
   int         errors;
   int         checks;
   integer     seed;

   ahb_ssram_top ahb_ssram_top_inst (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .HSEL      (HSEL),
      .HADDR     (HADDR),
      .HTRANS    (HTRANS),
      .HSIZE     (HSIZE),
      .HWRITE    (HWRITE),
      .HWDATA    (HWDATA),
      .HRDATA    (HRDATA),
      .HREADYOUT (HREADYOUT),
      .HRESP     (HRESP)
   );

   initial begin
      HCLK = 1'b0;
      forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
   end

   // Lanes touched by a transfer counted from the offset rounded down to the size
   function automatic logic [3:0] lane_mask(input hsize_e size, input logic [1:0] off);
      int         nbytes;
      int         first;
      logic [3:0] m;
      case (size)
         BYTE:    nbytes = 1;
         HALF:    nbytes = 2;
         default: nbytes = 4;
      endcase
      first = int'(off) - (int'(off) % nbytes);
      for (int i = 0; i < 4; i++) begin
         m[i] = (i >= first) && (i < first + nbytes);
      end
      return m;
   endfunction

   function automatic logic [`AHB_DW-1:0] model_word(input logic [`AHB_AW-1:0] addr);
      return {ref_mem[{addr[`AHB_AW-1:2], 2'd3}], ref_mem[{addr[`AHB_AW-1:2], 2'd2}],
              ref_mem[{addr[`AHB_AW-1:2], 2'd1}], ref_mem[{addr[`AHB_AW-1:2], 2'd0}]};
   endfunction

   task automatic push_xfer(input logic sel, input logic write, input htrans_e trans,
                            input hsize_e size, input logic [`AHB_AW-1:0] addr,
                            input logic [`AHB_DW-1:0] data);
      xfer_t x;
      x = '{sel, write, trans, size, addr, data};
      xq.push_back(x);
   endtask

   task automatic drive_addr(input xfer_t x);
      HSEL   <= x.sel;
      HADDR  <= x.addr;
      HTRANS <= x.trans;
      HSIZE  <= x.size;
      HWRITE <= x.write;
   endtask

   // Data phase done so writes go into the model and reads are checked against it
   task automatic finish_data(input xfer_t x, input logic [`AHB_DW-1:0] rdata);
      logic [3:0]         lanes;
      logic [`AHB_DW-1:0] mask;
      logic [`AHB_DW-1:0] exp;
      lanes = lane_mask(x.size, x.addr[1:0]);
      mask  = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
      // IDLE, BUSY and unselected slots leave no trace
      if (x.sel && (x.trans == NONSEQ || x.trans == SEQ)) begin
         if (x.write) begin
            for (int i = 0; i < 4; i++) begin
               if (lanes[i]) begin
                  ref_mem[{x.addr[`AHB_AW-1:2], 2'(i)}] = x.data[8*i +: 8];
               end
            end
         end else begin
            exp = model_word(x.addr) & mask;
            checks++;
            if ((rdata & mask) !== exp) begin
               errors++;
               $display("Mismatch at %0t: HRDATA addr 0x%03h expected 0x%08h actual 0x%08h",
                        $time, x.addr, exp, rdata & mask);
            end
         end
      end
   endtask

   // Pipelined master with the next address phase over the current data phase
   task automatic run_queue(output int waits);
      xfer_t              aph;
      xfer_t              dph;
      xfer_t              idle_x;
      logic               aph_v;
      logic               dph_v;
      logic               ready;
      logic [`AHB_DW-1:0] rdata;
      idle_x = '{1'b0, 1'b0, IDLE, WORD, '0, '0};
      waits  = 0;
      aph_v  = 1'b0;
      dph_v  = 1'b0;
      dph    = idle_x;
      @(posedge HCLK);
      if (xq.size() > 0) begin
         aph   = xq.pop_front();
         aph_v = 1'b1;
         drive_addr(aph);
      end
      while (aph_v || dph_v) begin
         // Outputs settled half a cycle after the edge
         @(negedge HCLK);
         ready = HREADYOUT;
         rdata = HRDATA;
         checks++;
         if (HRESP !== 1'b0) begin
            errors++;
            $display("Mismatch at %0t: HRESP expected 0 actual %b", $time, HRESP);
         end
         if (ready !== 1'b1) begin
            waits++;
         end
         @(posedge HCLK);
         if (ready === 1'b1) begin
            if (dph_v) begin
               finish_data(dph, rdata);
            end
            dph   = aph;
            dph_v = aph_v;
            // Write data belongs to the data phase that starts here
            if (dph_v && dph.write) begin
               HWDATA <= dph.data;
            end
            if (xq.size() > 0) begin
               aph   = xq.pop_front();
               aph_v = 1'b1;
            end else begin
               aph   = idle_x;
               aph_v = 1'b0;
            end
            drive_addr(aph);
         end
      end
   endtask

   task automatic check_waits(input int expected, input int actual);
      checks++;
      if (actual != expected) begin
         errors++;
         $display("Mismatch at %0t: HREADYOUT low cycles expected %0d actual %0d",
                  $time, expected, actual);
      end
   endtask

   task automatic print_result(input string name, input int err0);
      $display("%s: %0d errors", name, errors - err0);
   endtask

   task automatic word_write_read();
      int err0;
      int waits;
      err0 = errors;
      for (int i = 0; i < 8; i++) begin
         push_xfer(1'b1, 1'b1, NONSEQ, WORD, `AHB_AW'((i * 212) & ~3), $random(seed));
      end
      for (int i = 0; i < 8; i++) begin
         push_xfer(1'b1, 1'b0, SEQ, WORD, `AHB_AW'((i * 212) & ~3), '0);
      end
      run_queue(waits);
      print_result("word write and read-back", err0);
   endtask

   task automatic sub_word_lanes();
      int                 err0;
      int                 waits;
      logic [`AHB_AW-1:0] a;
      err0 = errors;
      for (int k = 0; k < 6; k++) begin
         a = `AHB_AW'(512 + 4 * k);
         push_xfer(1'b1, 1'b1, NONSEQ, WORD, a, 32'h8877_6655);
         // Four byte offsets and then both halfword offsets
         if (k < 4) begin
            push_xfer(1'b1, 1'b1, NONSEQ, BYTE, a + `AHB_AW'(k), $random(seed));
         end else begin
            push_xfer(1'b1, 1'b1, NONSEQ, HALF, a + `AHB_AW'(2 * (k - 4)), $random(seed));
         end
         push_xfer(1'b1, 1'b0, NONSEQ, WORD, a, '0);
      end
      run_queue(waits);
      print_result("byte and halfword lanes", err0);
   endtask

   task automatic write_then_read();
      int err0;
      int waits;
      err0 = errors;
      for (int i = 0; i < 4; i++) begin
         push_xfer(1'b1, 1'b1, NONSEQ, WORD, `AHB_AW'(768 + 4 * i), $random(seed));
         push_xfer(1'b1, 1'b0, NONSEQ, WORD, `AHB_AW'(768 + 4 * i), '0);
         run_queue(waits);
         // Read behind a write costs one wait state
         check_waits(1, waits);
      end
      print_result("write then read wait state", err0);
   endtask

   task automatic idle_transfers();
      int err0;
      int waits;
      err0 = errors;
      for (int i = 0; i < 4; i++) begin
         push_xfer(1'b1, 1'b1, NONSEQ, WORD, `AHB_AW'(1024 + 4 * i), $random(seed));
      end
      run_queue(waits);
      // HWRITE high with data inverted from what is stored
      push_xfer(1'b1, 1'b1, IDLE, WORD, `AHB_AW'(1024), ~model_word(`AHB_AW'(1024)));
      push_xfer(1'b1, 1'b1, BUSY, WORD, `AHB_AW'(1028), ~model_word(`AHB_AW'(1028)));
      push_xfer(1'b0, 1'b1, NONSEQ, WORD, `AHB_AW'(1032), ~model_word(`AHB_AW'(1032)));
      push_xfer(1'b0, 1'b1, SEQ, WORD, `AHB_AW'(1036), ~model_word(`AHB_AW'(1036)));
      run_queue(waits);
      check_waits(0, waits);
      for (int i = 0; i < 4; i++) begin
         push_xfer(1'b1, 1'b0, NONSEQ, WORD, `AHB_AW'(1024 + 4 * i), '0);
      end
      run_queue(waits);
      check_waits(0, waits);
      print_result("transfers that do not write", err0);
   endtask

   task automatic random_mix();
      int          err0;
      int          waits;
      logic [31:0] r;
      logic [1:0]  off;
      hsize_e      size;
      err0 = errors;
      // Known contents so every read has an expected value
      for (int w = 0; w < 8; w++) begin
         push_xfer(1'b1, 1'b1, NONSEQ, WORD, `AHB_AW'(256 + 4 * w), $random(seed));
      end
      for (int n = 0; n < 60; n++) begin
         r = $random(seed);
         case (r[3:2])
            2'd0:    size = BYTE;
            2'd1:    size = HALF;
            2'd2:    size = WORD;
            default: size = hsize_e'(3'b011);
         endcase
         // Offset aligned to the size
         off = (size == BYTE) ? r[8:7] : (size == HALF) ? {r[8], 1'b0} : 2'b00;
         push_xfer(1'b1, r[0], htrans_e'(r[1] ? SEQ : NONSEQ), size,
                   `AHB_AW'(256 + 4 * int'(r[6:4]) + int'(off)), $random(seed));
      end
      run_queue(waits);
      print_result("random mixed sequence", err0);
   endtask

   initial begin
      errors = 0;
      checks = 0;
      seed   = 66242;
      HRESETn <= 1'b0;
      HSEL    <= 1'b0;
      HADDR   <= '0;
      HTRANS  <= IDLE;
      HSIZE   <= WORD;
      HWRITE  <= 1'b0;
      HWDATA  <= '0;
      repeat (2) @(posedge HCLK);
      HRESETn <= 1'b1;
      word_write_read();
      sub_word_lanes();
      write_then_read();
      idle_transfers();
      random_mix();
      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // Watchdog against a bus that never becomes ready
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout after %0d cycles, HREADYOUT never completed the tests", WATCHDOG_CYCLES);
      $display("** FAIL **");
      $finish;
   end

endmodule
